//--- sources.f
hw/z80_dp_pkg.sv
hw/pair_write_decode.sv
hw/reg_pair.sv
hw/accum_alu.sv
hw/bus_select.sv
hw/z80_datapath.sv
testbench/tb_z80_datapath.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_z80_datapath
FILELIST = sources.f

BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Simulation completed successfully
SRCS    := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- testbench/tb_z80_datapath.sv
`timescale 1ns/100ps

module tb_z80_datapath;

  import z80_dp_pkg::*;

  logic     clk = 1'b0;
  logic     reset;
  dp_ctrl_t ctrl;
  byte_t    data_in;
  byte_t    data_out;
  word_t    addr_out;
  logic     data_drive;
  logic     addr_drive;

  // reference state of 14 live bytes, 6 shadow bytes and A
  byte_t live_hi [NUM_PAIRS];
  byte_t live_lo [NUM_PAIRS];
  word_t shadow  [NUM_SHADOWED];
  byte_t a_model;

  // what the buses should carry for the current control word
  word_t rd_word;
  word_t exp_alu16;
  byte_t exp_alu8;
  byte_t exp_data;
  word_t exp_addr;

  z80_datapath dut0 (
    .clk        (clk),
    .reset      (reset),
    .ctrl       (ctrl),
    .data_in    (data_in),
    .data_out   (data_out),
    .data_drive (data_drive),
    .addr_out   (addr_out),
    .addr_drive (addr_drive)
  );

  always #5 clk = ~clk;

  //--------------------------------------------------------------------------
  // reference model
  //--------------------------------------------------------------------------
  // bus values follow the control word in the same cycle
  always_comb begin
    rd_word   = {live_hi[ctrl.rd_pair], live_lo[ctrl.rd_pair]};
    exp_alu16 = rd_word;
    exp_alu8  = a_model;
    if (ctrl.alu_op == ALU_INC) begin
      exp_alu16 = rd_word + 16'd1;
      exp_alu8  = a_model + 8'd1;
    end else if (ctrl.alu_op == ALU_DEC) begin
      exp_alu16 = rd_word - 16'd1;
      exp_alu8  = a_model - 8'd1;
    end
    case (ctrl.data_src)
      DSRC_REG: exp_data = ctrl.rd_high ? rd_word[15:8] : rd_word[7:0];
      DSRC_A:   exp_data = a_model;
      DSRC_ALU: exp_data = exp_alu8;
      default:  exp_data = data_in;
    endcase
    case (ctrl.addr_src)
      ASRC_PAIR: exp_addr = rd_word;
      ASRC_ALU:  exp_addr = exp_alu16;
      default:   exp_addr = '0;
    endcase
  end

  // writes land at the edge that ends the cycle
  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_PAIRS; i++) begin
        live_hi[i] <= '0;
        live_lo[i] <= '0;
      end
      for (int i = 0; i < NUM_SHADOWED; i++) begin
        shadow[i] <= '0;
      end
      a_model <= '0;
    end else begin
      // BC, DE and HL trade places with their shadows
      if (ctrl.exx) begin
        for (int i = 0; i < NUM_SHADOWED; i++) begin
          {live_hi[i], live_lo[i]} <= shadow[i];
          shadow[i]                <= {live_hi[i], live_lo[i]};
        end
      end
      if (ctrl.ld_word) begin
        live_hi[ctrl.wr_pair] <= exp_addr[15:8];
        live_lo[ctrl.wr_pair] <= exp_addr[7:0];
      end
      if (ctrl.ld_byte && ctrl.wr_high) live_hi[ctrl.wr_pair] <= exp_data;
      if (ctrl.ld_byte && !ctrl.wr_high) live_lo[ctrl.wr_pair] <= exp_data;
      if (ctrl.ld_a) a_model <= exp_data;
    end
  end

  //--------------------------------------------------------------------------
  // checks sampled mid-cycle
  //--------------------------------------------------------------------------
  task automatic report_mismatch(input string name, input word_t expected,
                                 input word_t actual);
    $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    $display("Simulation failed");
    $fatal(1, "%s mismatch", name);
  endtask

  a_data_out: assert property (@(negedge clk) disable iff (reset) data_out == exp_data)
    else report_mismatch("data_out", 16'(exp_data), 16'(data_out));
  a_addr_out: assert property (@(negedge clk) disable iff (reset) addr_out == exp_addr)
    else report_mismatch("addr_out", exp_addr, addr_out);
  a_data_drive: assert property (@(negedge clk) disable iff (reset)
    data_drive == (ctrl.data_src != DSRC_EXT))
    else report_mismatch("data_drive", 16'(ctrl.data_src != DSRC_EXT), 16'(data_drive));
  a_addr_drive: assert property (@(negedge clk) disable iff (reset)
    addr_drive == (ctrl.addr_src != ASRC_NONE))
    else report_mismatch("addr_drive", 16'(ctrl.addr_src != ASRC_NONE), 16'(addr_drive));

  //--------------------------------------------------------------------------
  // stimulus
  //--------------------------------------------------------------------------
  // one control word for one cycle
  task automatic drive_cycle(input dp_ctrl_t c, input byte_t d);
    @(posedge clk);
    ctrl    <= c;
    data_in <= d;
  endtask

  // both halves from data_in, in random order
  task automatic load_pair(input int p);
    dp_ctrl_t c;
    c         = '0;
    c.ld_byte = 1'b1;
    c.wr_pair = pair_sel_t'(3'(p));
    c.wr_high = 1'($urandom_range(0, 1));
    drive_cycle(c, 8'($urandom));
    c.wr_high = ~c.wr_high;
    drive_cycle(c, 8'($urandom));
  endtask

  // every byte on data_out and every pair on addr_out
  task automatic read_all_pairs();
    dp_ctrl_t c;
    for (int p = 0; p < NUM_PAIRS; p++) begin
      for (int h = 0; h < 2; h++) begin
        c          = '0;
        c.rd_pair  = pair_sel_t'(3'(p));
        c.rd_high  = h[0];
        c.data_src = DSRC_REG;
        c.addr_src = ASRC_PAIR;
        drive_cycle(c, 8'($urandom));
      end
    end
  endtask

  // 16-bit ALU on one pair, result word-loaded into PC, then PC read back
  task automatic step_into_pc(input int p, input alu_op_t op);
    dp_ctrl_t c;
    c          = '0;
    c.rd_pair  = pair_sel_t'(3'(p));
    c.alu_op   = op;
    c.addr_src = ASRC_ALU;
    c.ld_word  = 1'b1;
    c.wr_pair  = PAIR_PC;
    drive_cycle(c, '0);
    c          = '0;
    c.rd_pair  = PAIR_PC;
    c.addr_src = ASRC_PAIR;
    drive_cycle(c, '0);
  endtask

  // A through the 8-bit ALU and back into A, then shown on data_out
  task automatic step_a(input alu_op_t op);
    dp_ctrl_t c;
    c          = '0;
    c.ld_a     = 1'b1;
    c.data_src = DSRC_ALU;
    c.alu_op   = op;
    drive_cycle(c, 8'($urandom));
    c          = '0;
    c.data_src = DSRC_A;
    drive_cycle(c, 8'($urandom));
  endtask

  initial begin
    dp_ctrl_t c;
    void'($urandom(32'he48e_2065));
    ctrl    = '0;
    data_in = '0;
    reset   = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // idle bus lets data_in through, registers all zero
    repeat (4) drive_cycle('0, 8'($urandom));
    read_all_pairs();

    // byte loads into all seven pairs
    for (int p = 0; p < NUM_PAIRS; p++) load_pair(p);
    read_all_pairs();

    // 16-bit ALU on random pairs
    for (int k = 0; k < 16; k++) begin
      step_into_pc(int'($urandom_range(0, 6)), alu_op_t'(2'($urandom_range(0, 2))));
    end
    // PC at FFFF wraps to zero and back
    step_into_pc(int'(PAIR_PC), ALU_PASS);
    for (int p = 0; p < 2; p++) begin
      c          = '0;
      c.ld_byte  = 1'b1;
      c.wr_pair  = PAIR_PC;
      c.wr_high  = p[0];
      drive_cycle(c, 8'hff);
    end
    step_into_pc(int'(PAIR_PC), ALU_INC);
    step_into_pc(int'(PAIR_PC), ALU_DEC);

    // accumulator wraps both ways around FF and 00
    c      = '0;
    c.ld_a = 1'b1;
    drive_cycle(c, 8'hfe);
    repeat (3) step_a(ALU_INC);
    repeat (4) step_a(ALU_DEC);
    step_a(ALU_PASS);

    // exx swaps BC, DE, HL but leaves IX alone
    for (int p = 0; p <= int'(PAIR_IX); p++) load_pair(p);
    c     = '0;
    c.exx = 1'b1;
    drive_cycle(c, '0);
    read_all_pairs();
    for (int p = 0; p < NUM_SHADOWED; p++) load_pair(p);
    // second swap brings the first set back
    drive_cycle(c, '0);
    read_all_pairs();

    drive_cycle('0, '0);
    repeat (2) @(negedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- hw/z80_datapath.sv
`timescale 1ns/100ps

module z80_datapath (
  input  logic                 clk,
  input  logic                 reset,
  input  z80_dp_pkg::dp_ctrl_t ctrl,
  input  z80_dp_pkg::byte_t    data_in,
  output z80_dp_pkg::byte_t    data_out,
  output logic                 data_drive,
  output z80_dp_pkg::word_t    addr_out,
  output logic                 addr_drive
);

  import z80_dp_pkg::*;

  //--------------------------------------------------------------------------
  // internal buses
  //--------------------------------------------------------------------------
  byte_t    data_int;
  word_t    addr_int;

  // per-pair write commands and read values
  pair_wr_t wr_cmd     [NUM_PAIRS];
  word_t    pair_value [NUM_PAIRS];

  // accumulator side
  byte_t    a_value;
  byte_t    alu8_result;

  // write side
  pair_write_decode u_decode (
    .ctrl   (ctrl),
    .wr_cmd (wr_cmd)
  );

  // BC, DE, HL get shadows
  // IX, IY, SP, PC do not
  for (genvar i = 0; i < NUM_PAIRS; i++) begin : g_pair
    reg_pair #(
      .has_shadow (i < NUM_SHADOWED)
    ) u_pair (
      .clk      (clk),
      .reset    (reset),
      .wr       (wr_cmd[i]),
      .data_int (data_int),
      .addr_int (addr_int),
      .value    (pair_value[i])
    );
  end

  accum_alu u_accum (
    .clk         (clk),
    .reset       (reset),
    .ld_a        (ctrl.ld_a),
    .alu_op      (ctrl.alu_op),
    .data_int    (data_int),
    .a_value     (a_value),
    .alu8_result (alu8_result)
  );

  // read side and both ALU outputs onto the buses
  bus_select u_bus (
    .ctrl        (ctrl),
    .pair_value  (pair_value),
    .a_value     (a_value),
    .alu8_result (alu8_result),
    .data_in     (data_in),
    .data_int    (data_int),
    .addr_int    (addr_int),
    .data_drive  (data_drive),
    .addr_drive  (addr_drive)
  );

  // pins follow the internal buses
  assign data_out = data_int;
  assign addr_out = addr_int;

endmodule

//--- hw/bus_select.sv
`timescale 1ns/100ps

module bus_select (
  input  z80_dp_pkg::dp_ctrl_t ctrl,
  input  z80_dp_pkg::word_t    pair_value [z80_dp_pkg::NUM_PAIRS],
  input  z80_dp_pkg::byte_t    a_value,
  input  z80_dp_pkg::byte_t    alu8_result,
  input  z80_dp_pkg::byte_t    data_in,
  output z80_dp_pkg::byte_t    data_int,
  output z80_dp_pkg::word_t    addr_int,
  output logic                 data_drive,
  output logic                 addr_drive
);

  import z80_dp_pkg::*;

  word_t rd_word;
  byte_t rd_byte;
  word_t alu16_result;

  //--------------------------------------------------------------------------
  // register read
  //--------------------------------------------------------------------------
  // pure mux
  // code 3'd7 reads as zero
  always_comb begin
    rd_word = '0;
    for (int i = 0; i < NUM_PAIRS; i++) begin
      if (int'(ctrl.rd_pair) == i) begin
        rd_word = pair_value[i];
      end
    end
  end

  // high half is B, D, H and so on
  assign rd_byte = ctrl.rd_high ? rd_word[15:8] : rd_word[7:0];

  //--------------------------------------------------------------------------
  // 16-bit ALU
  //--------------------------------------------------------------------------
  // steps PC and SP, wraps modulo 65536
  always_comb begin
    case (ctrl.alu_op)
      ALU_INC: alu16_result = rd_word + 16'd1;
      ALU_DEC: alu16_result = rd_word - 16'd1;
      default: alu16_result = rd_word;
    endcase
  end

  //--------------------------------------------------------------------------
  // bus muxes
  //--------------------------------------------------------------------------
  // encoded source so only one driver at a time
  always_comb begin
    case (ctrl.data_src)
      DSRC_REG: data_int = rd_byte;
      DSRC_A:   data_int = a_value;
      DSRC_ALU: data_int = alu8_result;
      default:  data_int = data_in;
    endcase
  end

  // idle address bus reads zero
  always_comb begin
    case (ctrl.addr_src)
      ASRC_PAIR: addr_int = rd_word;
      ASRC_ALU:  addr_int = alu16_result;
      default:   addr_int = '0;
    endcase
  end

  // external drive flags replace tristate
  assign data_drive = (ctrl.data_src != DSRC_EXT);
  assign addr_drive = (ctrl.addr_src != ASRC_NONE);

  // the unused address source code would silently park the bus at zero
  always_comb begin
    if (!$isunknown(ctrl)) begin
      a_src_legal: assert (ctrl.addr_src inside {ASRC_NONE, ASRC_PAIR, ASRC_ALU})
        else $error("bus source code out of range");
    end
  end

endmodule

//--- hw/accum_alu.sv
`timescale 1ns/100ps

module accum_alu (
  input  logic                clk,
  input  logic                reset,
  input  logic                ld_a,
  input  z80_dp_pkg::alu_op_t alu_op,
  input  z80_dp_pkg::byte_t   data_int,
  output z80_dp_pkg::byte_t   a_value,
  output z80_dp_pkg::byte_t   alu8_result
);

  import z80_dp_pkg::*;

  byte_t a_q;

  //--------------------------------------------------------------------------
  // accumulator
  //--------------------------------------------------------------------------
  // loads only from the internal data bus
  // in-place inc and dec come back around through DSRC_ALU
  always_ff @(posedge clk) begin
    if (reset) begin
      a_q <= '0;
    end else if (ld_a) begin
      a_q <= data_int;
    end
  end

  assign a_value = a_q;

  //--------------------------------------------------------------------------
  // 8-bit ALU
  //--------------------------------------------------------------------------
  // wraps modulo 256, no flags kept
  always_comb begin
    case (alu_op)
      ALU_INC: alu8_result = a_q + 8'd1;
      ALU_DEC: alu8_result = a_q - 8'd1;
      default: alu8_result = a_q;
    endcase
  end

endmodule

//--- hw/reg_pair.sv
`timescale 1ns/100ps

module reg_pair #(
  parameter bit has_shadow = 1'b0
) (
  input  logic                 clk,
  input  logic                 reset,
  input  z80_dp_pkg::pair_wr_t wr,
  input  z80_dp_pkg::byte_t    data_int,
  input  z80_dp_pkg::word_t    addr_int,
  output z80_dp_pkg::word_t    value
);

  import z80_dp_pkg::*;

  // live halves
  byte_t hi_q;
  byte_t lo_q;

  // what the live word becomes on exx
  word_t swap_word;
  logic  do_swap;

  //--------------------------------------------------------------------------
  // shadow copy, only for BC, DE and HL
  //--------------------------------------------------------------------------
  generate
    if (has_shadow) begin : g_shadow
      word_t shadow_q;

      // shadow takes the live word while live takes the shadow
      always_ff @(posedge clk) begin
        if (reset) begin
          shadow_q <= '0;
        end else if (wr.exx) begin
          shadow_q <= {hi_q, lo_q};
        end
      end

      assign swap_word = shadow_q;
      assign do_swap   = wr.exx;

      // full exchange in a single edge
      a_exx_swap: assert property (@(posedge clk) disable iff (reset)
        wr.exx |=> (value == $past(shadow_q)) && (shadow_q == $past(value)));
    end else begin : g_no_shadow
      // exx has no effect here
      assign swap_word = '0;
      assign do_swap   = 1'b0;
    end
  endgenerate

  //--------------------------------------------------------------------------
  // live register
  //--------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      hi_q <= '0;
      lo_q <= '0;
    end else if (do_swap) begin
      {hi_q, lo_q} <= swap_word;
    end else if (wr.word) begin
      // PC and SP stepping comes in this way
      {hi_q, lo_q} <= addr_int;
    end else begin
      if (wr.wr_hi) hi_q <= data_int;
      if (wr.wr_lo) lo_q <= data_int;
    end
  end

  assign value = {hi_q, lo_q};

endmodule

//--- hw/pair_write_decode.sv
`timescale 1ns/100ps

module pair_write_decode (
  input  z80_dp_pkg::dp_ctrl_t ctrl,
  output z80_dp_pkg::pair_wr_t wr_cmd [z80_dp_pkg::NUM_PAIRS]
);

  import z80_dp_pkg::*;

  //--------------------------------------------------------------------------
  // per-pair half enables
  //--------------------------------------------------------------------------
  always_comb begin
    logic hit;
    for (int i = 0; i < NUM_PAIRS; i++) begin
      // only the addressed pair sees a write
      hit = (int'(ctrl.wr_pair) == i);
      // byte writes pick one half by wr_high
      wr_cmd[i].wr_hi = hit & ctrl.ld_byte & ctrl.wr_high;
      wr_cmd[i].wr_lo = hit & ctrl.ld_byte & ~ctrl.wr_high;
      // word write takes both halves from the address bus
      wr_cmd[i].word  = hit & ctrl.ld_word;
      // exx goes to everyone
      // pairs without a shadow drop it
      wr_cmd[i].exx   = ctrl.exx;
    end
  end

  //--------------------------------------------------------------------------
  // sequencer sanity
  //--------------------------------------------------------------------------
  always_comb begin
    if (!$isunknown(ctrl)) begin
      // a pair takes either a byte or a word in one cycle
      a_one_load: assert (!(ctrl.ld_byte && ctrl.ld_word))
        else $error("byte and word load requested together");
      // the exchange owns the shadowed pairs for its cycle
      a_exx_alone: assert (!(ctrl.exx && (ctrl.ld_byte || ctrl.ld_word)))
        else $error("exx issued together with a register write");
    end
  end

endmodule

//--- hw/z80_dp_pkg.sv
package z80_dp_pkg;

  //--------------------------------------------------------------------------
  // widths and sizes
  //--------------------------------------------------------------------------
  localparam int BYTE_W = 8;
  localparam int WORD_W = 16;

  // BC through PC
  localparam int NUM_PAIRS = 7;
  // only BC, DE and HL have shadow copies
  localparam int NUM_SHADOWED = 3;

  // one register half or one data bus value
  typedef logic [BYTE_W-1:0] byte_t;
  // one register pair or one address bus value
  typedef logic [WORD_W-1:0] word_t;

  //--------------------------------------------------------------------------
  // encodings
  //--------------------------------------------------------------------------
  // order matters, shadowed pairs sit at the lowest indices
  typedef enum logic [2:0] {
    PAIR_BC,
    PAIR_DE,
    PAIR_HL,
    PAIR_IX,
    PAIR_IY,
    PAIR_SP,
    PAIR_PC
  } pair_sel_t;

  // shared by the 8-bit and the 16-bit ALU
  typedef enum logic [1:0] {
    ALU_PASS = 2'd0,
    ALU_INC  = 2'd1,
    ALU_DEC  = 2'd2
  } alu_op_t;

  // internal data bus source
  // DSRC_EXT lets data_in through and leaves the pins undriven
  typedef enum logic [1:0] {
    DSRC_EXT = 2'd0,
    DSRC_REG = 2'd1,
    DSRC_A   = 2'd2,
    DSRC_ALU = 2'd3
  } data_src_t;

  // internal address bus source
  typedef enum logic [1:0] {
    ASRC_NONE = 2'd0,
    ASRC_PAIR = 2'd1,
    ASRC_ALU  = 2'd2
  } addr_src_t;

  //--------------------------------------------------------------------------
  // control word from the microsequencer, one per cycle
  //--------------------------------------------------------------------------
  typedef struct packed {
    logic      ld_byte;   // write one half from the data bus
    logic      ld_word;   // write a whole pair from the address bus
    pair_sel_t wr_pair;
    logic      wr_high;   // high half for byte writes
    pair_sel_t rd_pair;
    logic      rd_high;   // high half onto the data bus
    data_src_t data_src;
    addr_src_t addr_src;
    logic      ld_a;
    alu_op_t   alu_op;    // applies to both ALUs
    logic      exx;       // swap BC, DE, HL with their shadows
  } dp_ctrl_t;

  // write command for one pair
  typedef struct packed {
    logic wr_hi;
    logic wr_lo;
    logic word;
    logic exx;
  } pair_wr_t;

endpackage
